// File: Makefile
VERILATOR = verilator
TOP       = main_bus_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
FLAGS     = --timing --assert --top-module $(TOP) -f $(FILELIST)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS)

sim:
	$(VERILATOR) --binary $(FLAGS) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: src.f
verilog/main_pkg.sv
verilog/cpu_bus_if.sv
verilog/main_bus_ctrl.sv
verilog/vram_port.sv
verilog/io_regs.sv
verilog/main_bus.sv
tb/main_bus_asserts.sv
tb/main_bus_tb.sv

// File: tb/main_bus_asserts.sv
// bus protocol, blanking and interrupt priority checks, bound onto the main bus top level
`timescale 1ns/1ns

module main_bus_asserts (
    input logic        clk,
    input logic        rst,
    input logic        req_valid,
    input logic        req_ready,
    input logic [23:1] req_addr,
    input logic        lvbl,
    input logic        lhbl,
    input logic        nexirq,
    input logic        sec2,
    input logic        snreq,
    input logic [2:0]  ipl_n
);

    logic blank;
    logic vram_req;

    assign blank    = ~lvbl | ~lhbl;
    assign vram_req = req_addr[23:22] == 2'b00 && req_addr[21:20] == main_pkg::REGION_DISP
                   && req_addr[19:18] == main_pkg::DISP_SEL;

    ack_needs_valid: assert property (@(posedge clk) disable iff (rst) req_ready |-> req_valid)
        else $error("req_ready high without req_valid");

    snreq_single: assert property (@(posedge clk) disable iff (rst) snreq |=> !snreq)
        else $error("snreq high for two cycles");

    vram_in_blank: assert property (@(posedge clk) disable iff (rst)
        req_ready && vram_req |-> blank && $past(blank))
        else $error("video RAM acknowledged outside blanking");

    // vblank start outranks every other cause
    ipl_vblank: assert property (@(posedge clk) disable iff (rst)
        $fell(lvbl) |=> ipl_n == ~3'd6)
        else $error("ipl_n not at level 6 after vertical blank start");

    ipl_sub_cpu: assert property (@(posedge clk) disable iff (rst)
        $rose(sec2) |=> ipl_n inside {~3'd6, ~3'd5})
        else $error("ipl_n below level 5 after a sub-CPU request");

    ipl_external: assert property (@(posedge clk) disable iff (rst)
        !nexirq |-> ipl_n inside {~3'd6, ~3'd5, ~3'd4})
        else $error("ipl_n below level 4 while nexirq is low");

    ipl_level4: assert property (@(posedge clk) disable iff (rst)
        ipl_n == ~3'd4 |-> !nexirq)
        else $error("ipl_n at level 4 without nexirq low");

endmodule

bind main_bus main_bus_asserts main_bus_asserts_i (
    .clk       (clk),
    .rst       (rst),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_addr  (req_addr),
    .lvbl      (lvbl),
    .lhbl      (lhbl),
    .nexirq    (nexirq),
    .sec2      (sec2),
    .snreq     (snreq),
    .ipl_n     (ipl_n)
);

// File: tb/main_bus_tb.sv
// testbench for the main bus glue; drives CPU transfers and board inputs and checks each response
`timescale 1ns/1ns

module main_bus_tb;

    localparam int TIMEOUT = 50;    // cycles allowed for any wait

    logic        clk, rst, req_valid, req_we, req_ready;
    logic [23:1] req_addr;
    logic [15:0] req_wdata, rsp_rdata, mcu_dout, mcu_din;
    logic        lvbl, lhbl, nexirq, sec2, service;
    logic [8:0]  joystick1, joystick2;
    logic [1:0]  start_button, coin_input;
    logic [7:0]  dipsw_a, dipsw_b, snd_latch;
    logic [2:0]  ipl_n, prisel;
    logic        snreq, mixpsel;
    int          snreq_seen;
    logic [15:0] rdata, wdata;
    logic [7:0]  words [4];
    logic [15:0] vals [4];

    main_bus main_bus_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(negedge clk) begin
        if (snreq)
            snreq_seen <= snreq_seen + 1;     // sound request pulses
    end

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic start_req(input logic [23:1] addr, input logic we, input logic [15:0] data);
        @(posedge clk);
        req_valid <= 1'b1;
        req_addr  <= addr;
        req_we    <= we;
        req_wdata <= data;
    endtask

    // hold the request until acknowledged, then release it
    task automatic wait_ack(output logic [15:0] data);
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("no bus acknowledge within %0d cycles", TIMEOUT);
                abort_run();
            end
        end while (!req_ready);
        data = rsp_rdata;
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_xfer(input logic [23:1] addr, input logic we, input logic [15:0] data,
                            output logic [15:0] rd);
        start_req(addr, we, data);
        wait_ack(rd);
    endtask

    task automatic wait_ipl(input logic [2:0] exp);
        int waited;
        waited = 0;
        while (ipl_n !== exp) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("[FAIL] ipl_n got %h expected %h", ipl_n, exp);
                abort_run();
            end
        end
    endtask

    function automatic logic [23:1] io_addr(input logic dir, input logic [2:0] idx);
        return {2'b00, main_pkg::REGION_IO, 3'b000, main_pkg::IO_BLOCK, 9'd0, dir, idx};
    endfunction

    function automatic logic [23:1] vram_addr(input logic [7:0] word);
        return {2'b00, main_pkg::REGION_DISP, main_pkg::DISP_SEL, 9'd0, word};
    endfunction

    // cabinet byte, low nibble mirrored
    function automatic logic [7:0] joy_byte(input logic [8:0] joy);
        logic [7:0] b;
        b[7:4] = joy[7:4];
        for (int i = 0; i < 4; i++)
            b[i] = joy[3 - i];
        return b;
    endfunction

    initial begin
        void'($urandom(32'h3c12_1438));
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_we       = 1'b0;
        req_wdata    = '0;
        lvbl         = 1'b1;          // active display
        lhbl         = 1'b1;
        nexirq       = 1'b1;
        sec2         = 1'b0;
        service      = 1'b0;
        joystick1    = '0;
        joystick2    = '0;
        start_button = '0;
        coin_input   = '0;
        dipsw_a      = '0;
        dipsw_b      = '0;
        mcu_dout     = '0;
        snreq_seen   = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        repeat (3) begin
            @(posedge clk);
            joystick1    <= 9'($urandom);
            joystick2    <= 9'($urandom);
            start_button <= 2'($urandom);
            coin_input   <= 2'($urandom);
            service      <= 1'($urandom);
            dipsw_a      <= 8'($urandom);
            dipsw_b      <= 8'($urandom);
            bus_xfer(io_addr(1'b0, main_pkg::REG_JOY), 1'b0, 16'h0, rdata);
            check_value("rsp_rdata", rdata, {joy_byte(joystick2), joy_byte(joystick1)});
            bus_xfer(io_addr(1'b0, main_pkg::REG_BTN), 1'b0, 16'h0, rdata);
            check_value("rsp_rdata", rdata, {8'hff, ~lvbl, service, coin_input, start_button,
                                             joystick2[8], joystick1[8]});
            bus_xfer(io_addr(1'b0, main_pkg::REG_DIP), 1'b0, 16'h0, rdata);
            check_value("rsp_rdata", rdata, {dipsw_b, dipsw_a});
        end

        wdata = 16'($urandom);
        bus_xfer(io_addr(1'b1, main_pkg::REG_SND), 1'b1, wdata, rdata);
        check_value("snd_latch", {8'h00, snd_latch}, {8'h00, wdata[7:0]});
        check_value("snreq count", 16'(snreq_seen), 16'd1);
        bus_xfer(io_addr(1'b1, main_pkg::REG_PRI), 1'b1, wdata, rdata);
        check_value("prisel", {13'd0, prisel}, {13'd0, wdata[2:0]});
        bus_xfer(io_addr(1'b1, main_pkg::REG_MCU_WR), 1'b1, wdata, rdata);
        check_value("mcu_din", mcu_din, wdata);
        bus_xfer(io_addr(1'b1, main_pkg::REG_MIX), 1'b1, wdata, rdata);
        check_value("mixpsel", {15'd0, mixpsel}, {15'd0, wdata[0]});
        // write into the read group, then read from the write group
        bus_xfer(io_addr(1'b0, main_pkg::REG_SND), 1'b1, ~wdata, rdata);
        check_value("rsp_rdata", rdata, main_pkg::OPEN_BUS);
        check_value("snd_latch", {8'h00, snd_latch}, {8'h00, wdata[7:0]});
        check_value("snreq count", 16'(snreq_seen), 16'd1);
        bus_xfer(io_addr(1'b1, main_pkg::REG_PRI), 1'b0, 16'h0, rdata);
        check_value("rsp_rdata", rdata, main_pkg::OPEN_BUS);
        check_value("prisel", {13'd0, prisel}, {13'd0, wdata[2:0]});

        for (int i = 0; i < 4; i++) begin
            words[i] = {2'(i), 6'($urandom)};     // top bits keep the words apart
            vals[i]  = 16'($urandom);
        end
        start_req(vram_addr(words[0]), 1'b1, vals[0]);
        repeat (10) begin
            @(negedge clk);
            check_value("req_ready", {15'd0, req_ready}, 16'd0);
        end
        @(posedge clk);
        lhbl <= 1'b0;                 // horizontal blank opens the window
        wait_ack(rdata);
        for (int i = 1; i < 4; i++)
            bus_xfer(vram_addr(words[i]), 1'b1, vals[i], rdata);
        for (int i = 0; i < 4; i++) begin
            bus_xfer(vram_addr(words[i]), 1'b0, 16'h0, rdata);
            check_value("rsp_rdata", rdata, vals[i]);
        end

        @(posedge clk);
        lhbl <= 1'b1;
        lvbl <= 1'b0;
        wait_ipl(~3'd6);
        @(posedge clk);
        lvbl <= 1'b1;
        bus_xfer(io_addr(1'b1, main_pkg::REG_VCLR), 1'b1, 16'h0, rdata);
        check_value("ipl_n", {13'd0, ipl_n}, 16'h0007);
        @(posedge clk);
        mcu_dout <= 16'($urandom);
        sec2     <= 1'b1;
        wait_ipl(~3'd5);
        @(posedge clk);
        sec2 <= 1'b0;
        bus_xfer(io_addr(1'b0, main_pkg::REG_MCU_RD), 1'b0, 16'h0, rdata);
        check_value("rsp_rdata", rdata, mcu_dout);
        check_value("ipl_n", {13'd0, ipl_n}, 16'h0007);
        @(posedge clk);
        nexirq <= 1'b0;
        wait_ipl(~3'd4);
        @(posedge clk);
        nexirq <= 1'b1;
        wait_ipl(3'b111);

        bus_xfer(23'h0, 1'b0, 16'h0, rdata);        // bank 0, region 0
        check_value("rsp_rdata", rdata, main_pkg::OPEN_BUS);
        bus_xfer(io_addr(1'b0, 3'd3), 1'b0, 16'h0, rdata);
        check_value("rsp_rdata", rdata, main_pkg::OPEN_BUS);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: verilog/cpu_bus_if.sv
// one decoded CPU request and its response, passed from the bus controller to a target
`timescale 1ns/1ns

interface cpu_bus_if;

    logic                  valid;   // held until ready
    main_pkg::bus_addr_u   addr;
    logic                  we;      // 1 for a CPU write
    logic [15:0]           wdata;
    logic                  ready;   // transfer acknowledge
    logic [15:0]           rdata;   // sampled with ready

    modport ctrl (
        output valid,
        output addr,
        output we,
        output wdata,
        input  ready,
        input  rdata
    );

    modport target (
        input  valid,
        input  addr,
        input  we,
        input  wdata,
        output ready,
        output rdata
    );

endinterface

// File: verilog/io_regs.sv
// cabinet inputs, CPU write latches and interrupt priority encoder of the I/O register window
`timescale 1ns/1ns

module io_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic        lvbl,
    input  logic        nexirq,         // active low
    input  logic        sec2,           // sub-CPU request, rising edge
    input  logic [8:0]  joystick1,
    input  logic [8:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [15:0] mcu_dout,
    output logic [2:0]  ipl_n,
    output logic [7:0]  snd_latch,
    output logic        snreq,
    output logic [15:0] mcu_din,
    output logic [2:0]  prisel,
    output logic        mixpsel,
    cpu_bus_if.target   bus
);

    logic       accept;
    logic       rd_ok;
    logic       wr_ok;
    logic [2:0] idx;
    logic       vint;
    logic       secirq;
    logic       lvbl_l;
    logic       sec2_l;

    // direction bits swapped within the low nibble
    function automatic logic [7:0] joy_reorder(input logic [8:0] joy);
        return {joy[7:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    assign accept = bus.valid & ~bus.ready;
    assign idx    = bus.addr.io.idx;
    assign rd_ok  = accept & ~bus.we & ~bus.addr.io.dir;
    assign wr_ok  = accept & bus.we & bus.addr.io.dir;   // wrong direction just acks

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bus.ready <= 1'b0;
            snreq     <= 1'b0;
            snd_latch <= 8'd0;
            mcu_din   <= 16'd0;
            prisel    <= 3'd0;
            mixpsel   <= 1'b0;
            vint      <= 1'b0;
            secirq    <= 1'b0;
            lvbl_l    <= 1'b0;
            sec2_l    <= 1'b0;
        end else begin
            bus.ready <= accept;
            snreq     <= wr_ok && idx == main_pkg::REG_SND;
            lvbl_l    <= lvbl;
            sec2_l    <= sec2;
            if (wr_ok) begin
                case (idx)
                    main_pkg::REG_PRI:    prisel    <= bus.wdata[2:0];
                    main_pkg::REG_SND:    snd_latch <= bus.wdata[7:0];
                    main_pkg::REG_MCU_WR: mcu_din   <= bus.wdata;
                    main_pkg::REG_MIX:    mixpsel   <= bus.wdata[0];
                    default: ;
                endcase
            end
            if (wr_ok && idx == main_pkg::REG_VCLR)
                vint <= 1'b0;
            else if (!lvbl && lvbl_l)
                vint <= 1'b1;           // start of vertical blank
            if (rd_ok && idx == main_pkg::REG_MCU_RD)
                secirq <= 1'b0;         // reading the mailbox clears it
            else if (sec2 && !sec2_l)
                secirq <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            bus.rdata <= main_pkg::OPEN_BUS;
            if (rd_ok) begin
                case (idx)
                    main_pkg::REG_JOY:
                        bus.rdata <= {joy_reorder(joystick2), joy_reorder(joystick1)};
                    main_pkg::REG_BTN:
                        bus.rdata <= {8'hff, ~lvbl, service, coin_input, start_button,
                                      joystick2[8], joystick1[8]};
                    main_pkg::REG_DIP:    bus.rdata <= {dipsw_b, dipsw_a};
                    main_pkg::REG_MCU_RD: bus.rdata <= mcu_dout;
                    default: ;
                endcase
            end
        end
    end

    // active low level, highest cause wins
    always_comb begin
        if (vint)
            ipl_n = ~3'd6;
        else if (secirq)
            ipl_n = ~3'd5;
        else if (!nexirq)
            ipl_n = ~3'd4;
        else
            ipl_n = 3'b111;
    end

endmodule

// File: verilog/main_bus.sv
// top level of the main CPU bus glue, one valid/ready request port and the board side signals
`timescale 1ns/1ns

module main_bus (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic [23:1] req_addr,       // word address
    input  logic        req_we,
    input  logic [15:0] req_wdata,
    output logic        req_ready,      // acts as DTACK
    output logic [15:0] rsp_rdata,
    input  logic        lvbl,
    input  logic        lhbl,
    input  logic        nexirq,
    input  logic        sec2,
    input  logic [8:0]  joystick1,
    input  logic [8:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [15:0] mcu_dout,
    output logic [2:0]  ipl_n,
    output logic [7:0]  snd_latch,
    output logic        snreq,
    output logic [15:0] mcu_din,
    output logic [2:0]  prisel,
    output logic        mixpsel
);

    cpu_bus_if vram_bus ();
    cpu_bus_if io_bus ();

    main_bus_ctrl main_bus_ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_addr  (req_addr),
        .req_we    (req_we),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_rdata (rsp_rdata),
        .vram_bus  (vram_bus.ctrl),
        .io_bus    (io_bus.ctrl)
    );

    vram_port vram_port_i (
        .clk  (clk),
        .rst  (rst),
        .lvbl (lvbl),
        .lhbl (lhbl),
        .bus  (vram_bus.target)
    );

    io_regs io_regs_i (
        .clk          (clk),
        .rst          (rst),
        .lvbl         (lvbl),
        .nexirq       (nexirq),
        .sec2         (sec2),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .mcu_dout     (mcu_dout),
        .ipl_n        (ipl_n),
        .snd_latch    (snd_latch),
        .snreq        (snreq),
        .mcu_din      (mcu_din),
        .prisel       (prisel),
        .mixpsel      (mixpsel),
        .bus          (io_bus.target)
    );

endmodule

// File: verilog/main_bus_ctrl.sv
// bus controller: decodes each request, steers it to video RAM or I/O and returns the acknowledge
`timescale 1ns/1ns

module main_bus_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    input  main_pkg::bus_addr_u req_addr,
    input  logic                req_we,
    input  logic [15:0]         req_wdata,
    output logic                req_ready,
    output logic [15:0]         rsp_rdata,
    cpu_bus_if.ctrl             vram_bus,
    cpu_bus_if.ctrl             io_bus
);

    logic ack_mask;     // blocks the cycle right after an acknowledge
    logic open_ack;     // delayed acknowledge for unmapped space
    logic req_act;
    logic bank_ok;
    logic vram_hit;
    logic io_hit;
    logic unmapped;

    assign req_act = req_valid & ~ack_mask;

    // top bits shared by both layouts
    assign bank_ok = req_addr.disp.bank == 2'b00;

    assign vram_hit = bank_ok
                   && req_addr.disp.region == main_pkg::REGION_DISP
                   && req_addr.disp.sel == main_pkg::DISP_SEL;

    assign io_hit = bank_ok
                 && req_addr.io.region == main_pkg::REGION_IO
                 && req_addr.io.block == main_pkg::IO_BLOCK;

    assign unmapped = ~vram_hit & ~io_hit;

    // request fields go to both targets, only one sees valid
    assign vram_bus.valid = req_act & vram_hit;
    assign vram_bus.addr  = req_addr;
    assign vram_bus.we    = req_we;
    assign vram_bus.wdata = req_wdata;

    assign io_bus.valid = req_act & io_hit;
    assign io_bus.addr  = req_addr;
    assign io_bus.we    = req_we;
    assign io_bus.wdata = req_wdata;

    always_comb begin
        if (vram_hit) begin
            req_ready = vram_bus.ready;
            rsp_rdata = vram_bus.rdata;
        end else if (io_hit) begin
            req_ready = io_bus.ready;
            rsp_rdata = io_bus.rdata;
        end else begin
            req_ready = open_ack & req_act;
            rsp_rdata = main_pkg::OPEN_BUS;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_mask <= 1'b0;
            open_ack <= 1'b0;
        end else begin
            ack_mask <= req_ready;
            open_ack <= req_act & unmapped & ~open_ack;     // one cycle after the request
        end
    end

endmodule

// File: verilog/main_pkg.sv
// shared address layout, region codes and register map for the main bus glue; referenced by scope
package main_pkg;

    localparam int VRAM_AW    = 8;          // video RAM word address width
    localparam int BLANK_WAIT = 2;          // blank cycles before a video access completes

    localparam logic [1:0]  REGION_DISP = 2'd2;
    localparam logic [1:0]  REGION_IO   = 2'd3;
    localparam logic [1:0]  DISP_SEL    = 2'b01;
    localparam logic [2:0]  IO_BLOCK    = 3'd3;
    localparam logic [15:0] OPEN_BUS    = 16'hffff;

    // read group, dir bit low
    localparam logic [2:0] REG_JOY    = 3'd0;
    localparam logic [2:0] REG_BTN    = 3'd1;
    localparam logic [2:0] REG_DIP    = 3'd2;
    localparam logic [2:0] REG_MCU_RD = 3'd4;
    // write group, dir bit high
    localparam logic [2:0] REG_PRI    = 3'd0;
    localparam logic [2:0] REG_SND    = 3'd2;
    localparam logic [2:0] REG_MCU_WR = 3'd3;
    localparam logic [2:0] REG_VCLR   = 3'd4;
    localparam logic [2:0] REG_MIX    = 3'd5;

    // 23-bit word address A[23:1], seen either as display or as I/O space
    typedef union packed {
        struct packed {
            logic [1:0]          bank;      // A[23:22], zero for any mapped area
            logic [1:0]          region;    // A[21:20]
            logic [1:0]          sel;       // A[19:18]
            logic [16-VRAM_AW:0] rsvd;      // mirrored, not decoded
            logic [VRAM_AW-1:0]  word;      // video RAM index
        } disp;
        struct packed {
            logic [1:0] bank;
            logic [1:0] region;
            logic [2:0] rsvd_hi;            // A[19:17]
            logic [2:0] block;              // A[16:14]
            logic [8:0] rsvd_lo;            // A[13:5]
            logic       dir;                // 1 selects the write group
            logic [2:0] idx;                // register index
        } io;
    } bus_addr_u;

endpackage

// File: verilog/vram_port.sv
// video RAM window; CPU accesses are held off until blanking has lasted long enough
`timescale 1ns/1ns

module vram_port (
    input  logic      clk,
    input  logic      rst,
    input  logic      lvbl,         // low during vertical blank
    input  logic      lhbl,         // low during horizontal blank
    cpu_bus_if.target bus
);

    logic [15:0]                  mem [0:(2**main_pkg::VRAM_AW)-1];
    logic [main_pkg::VRAM_AW-1:0] word;
    logic [15:0]                  rd_q;
    logic [1:0]                   blank_cnt;    // blank cycles seen by the waiting request
    logic                         blank;

    assign blank = ~lvbl | ~lhbl;
    assign word  = bus.addr.disp.word;

    // complete on the last of the required blank cycles
    assign bus.ready = bus.valid & blank
                     & (blank_cnt == 2'(main_pkg::BLANK_WAIT - 1));

    assign bus.rdata = rd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blank_cnt <= 2'd0;
        end else if (!bus.valid || !blank || bus.ready) begin
            blank_cnt <= 2'd0;      // restart when blank ends
        end else if (blank_cnt != 2'(main_pkg::BLANK_WAIT - 1)) begin
            blank_cnt <= blank_cnt + 2'd1;
        end
    end

    // request is stable while waiting, so the read is ready before ack
    always_ff @(posedge clk) begin
        if (bus.valid) begin
            rd_q <= mem[word];
        end
        if (bus.ready && bus.we) begin
            mem[word] <= bus.wdata;
        end
    end

endmodule
